// File: common/datapathPkg.sv
package datapathPkg;

        localparam int wordWidth = 32;
        localparam int registerCount = 16;

        // alu opcodes, numbered from 5 upward.
        typedef enum logic [4:0] {
                opAnd = 5'd5,
                opOr  = 5'd6,
                opAdd = 5'd7,
                opSub = 5'd8,
                opMul = 5'd9,
                opShr = 5'd10,
                opShl = 5'd11,
                opRor = 5'd12,
                opRol = 5'd13,
                opNeg = 5'd14,
                opNot = 5'd15,
                opInc = 5'd16
        } aluOp;

        // bus sources, lower index wins.
        typedef enum logic [4:0] {
                srcR0 = 5'd0,
                srcR1, srcR2, srcR3,
                srcR4, srcR5, srcR6, srcR7,
                srcR8, srcR9, srcR10, srcR11,
                srcR12, srcR13, srcR14, srcR15,
                srcHi,
                srcLo,
                srcZHigh,
                srcZLow,
                srcPc,
                srcMdr,
                srcInPort,
                srcNone
        } busSource;

endpackage

// File: logic/busEncoder.sv
module busEncoder (
        input  logic [datapathPkg::wordWidth-1:0]     regSources [datapathPkg::registerCount],
        input  logic [datapathPkg::registerCount-1:0] regOut,
        input  logic                                  hiOut,
        input  logic                                  loOut,
        input  logic                                  zHighOut,
        input  logic                                  zLowOut,
        input  logic                                  pcOut,
        input  logic                                  mdrOut,
        input  logic                                  inPortOut,
        input  logic [datapathPkg::wordWidth-1:0]     hi,
        input  logic [datapathPkg::wordWidth-1:0]     lo,
        input  logic [datapathPkg::wordWidth-1:0]     zHigh,
        input  logic [datapathPkg::wordWidth-1:0]     zLow,
        input  logic [datapathPkg::wordWidth-1:0]     pc,
        input  logic [datapathPkg::wordWidth-1:0]     mdr,
        input  logic [datapathPkg::wordWidth-1:0]     inPort,
        output logic [datapathPkg::wordWidth-1:0]     busData
);

        logic [31:0] request;
        datapathPkg::busSource sourceSelect;

        // bit position matches the busSource value.
        assign request = {
                9'b0,
                inPortOut,
                mdrOut,
                pcOut,
                zLowOut,
                zHighOut,
                loOut,
                hiOut,
                regOut
        };

        // walk downward so the lowest active index is left last.
        always_comb begin
                sourceSelect = datapathPkg::srcNone;
                for (int i = 31; i >= 0; i--) begin
                        if (request[i]) begin
                                sourceSelect = datapathPkg::busSource'(i);
                        end
                end
        end

        always_comb begin
                case (sourceSelect)
                        datapathPkg::srcHi:     busData = hi;
                        datapathPkg::srcLo:     busData = lo;
                        datapathPkg::srcZHigh:  busData = zHigh;
                        datapathPkg::srcZLow:   busData = zLow;
                        datapathPkg::srcPc:     busData = pc;
                        datapathPkg::srcMdr:    busData = mdr;
                        datapathPkg::srcInPort: busData = inPort;
                        datapathPkg::srcNone:   busData = '0; // idle bus reads zero.
                        default: begin
                                // R0 to R15, index is the register number.
                                busData = regSources[sourceSelect[3:0]];
                        end
                endcase
        end

endmodule

// File: logic/registerFile.sv
module registerFile (
        input  logic                                  Clock,
        input  logic                                  reset,
        input  logic [datapathPkg::registerCount-1:0] regIn,
        input  logic [datapathPkg::wordWidth-1:0]     busData,
        output logic [datapathPkg::wordWidth-1:0]     regSources [datapathPkg::registerCount]
);

        logic [datapathPkg::wordWidth-1:0] registers [datapathPkg::registerCount];

        // each register has its own load strobe, several may load at once.
        always_ff @(posedge Clock) begin
                if (reset) begin
                        for (int i = 0; i < datapathPkg::registerCount; i++) begin
                                registers[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < datapathPkg::registerCount; i++) begin
                                if (regIn[i]) begin
                                        registers[i] <= busData;
                                end
                        end
                end
        end

        // whole file visible to the bus encoder.
        always_comb begin
                for (int i = 0; i < datapathPkg::registerCount; i++) begin
                        regSources[i] = registers[i];
                end
        end

endmodule

// File: logic/memoryDataRegister.sv
module memoryDataRegister (
        input  logic                              Clock,
        input  logic                              reset,
        input  logic                              mdrIn,
        input  logic                              read,
        input  logic [datapathPkg::wordWidth-1:0] memDataIn,
        input  logic [datapathPkg::wordWidth-1:0] busData,
        output logic [datapathPkg::wordWidth-1:0] mdr
);

        logic [datapathPkg::wordWidth-1:0] nextValue;

        // memory side wins while read is high.
        assign nextValue = read ? memDataIn : busData;

        always_ff @(posedge Clock) begin
                if (reset) begin
                        mdr <= '0;
                end else if (mdrIn) begin
                        mdr <= nextValue;
                end
        end

endmodule

// File: alu/arithmeticLogicUnit.sv
module arithmeticLogicUnit (
        input  logic [datapathPkg::wordWidth-1:0]   operandA,
        input  logic [datapathPkg::wordWidth-1:0]   operandB,
        input  datapathPkg::aluOp                   operation,
        output logic [2*datapathPkg::wordWidth-1:0] result
);

        logic [4:0]                          shiftAmount;
        logic [2*datapathPkg::wordWidth-1:0] doubledA;
        logic [2*datapathPkg::wordWidth-1:0] rotatedRight;
        logic [2*datapathPkg::wordWidth-1:0] rotatedLeft;
        logic signed [2*datapathPkg::wordWidth-1:0] product;
        logic [datapathPkg::wordWidth-1:0]   lowResult;
        logic                                wideResult;

        assign shiftAmount = operandB[4:0];

        // rotate through a doubled copy of A.
        assign doubledA     = {operandA, operandA};
        assign rotatedRight = doubledA >> shiftAmount;
        assign rotatedLeft  = doubledA << shiftAmount;

        // signed operands extend to 64 bits in this context.
        assign product = $signed(operandA) * $signed(operandB);

        always_comb begin
                lowResult  = '0;
                wideResult = 1'b0;
                case (operation)
                        datapathPkg::opAnd: begin
                                lowResult = operandA & operandB;
                        end
                        datapathPkg::opOr: begin
                                lowResult = operandA | operandB;
                        end
                        datapathPkg::opAdd: begin
                                lowResult = operandA + operandB; // wraps.
                        end
                        datapathPkg::opSub: begin
                                lowResult = operandA - operandB;
                        end
                        datapathPkg::opMul: begin
                                wideResult = 1'b1;
                        end
                        datapathPkg::opShr: begin
                                lowResult = operandA >> shiftAmount; // logical.
                        end
                        datapathPkg::opShl: begin
                                lowResult = operandA << shiftAmount;
                        end
                        datapathPkg::opRor: begin
                                lowResult = rotatedRight[datapathPkg::wordWidth-1:0];
                        end
                        datapathPkg::opRol: begin
                                lowResult = rotatedLeft[2*datapathPkg::wordWidth-1:
                                        datapathPkg::wordWidth];
                        end
                        datapathPkg::opNeg: begin
                                lowResult = -operandB; // B only.
                        end
                        datapathPkg::opNot: begin
                                lowResult = ~operandB;
                        end
                        datapathPkg::opInc: begin
                                lowResult = operandB + 1'b1; // pc advance.
                        end
                        default: begin
                                lowResult = '0;
                        end
                endcase
        end

        // only multiply fills the high half.
        always_comb begin
                if (wideResult) begin
                        result = product;
                end else begin
                        result = {{datapathPkg::wordWidth{1'b0}}, lowResult};
                end
        end

endmodule

// File: logic/datapath.sv
module datapath (
        input  logic                                  Clock,
        input  logic                                  reset,
        input  logic [datapathPkg::registerCount-1:0] regIn,
        input  logic [datapathPkg::registerCount-1:0] regOut,
        input  logic                                  hiIn,
        input  logic                                  loIn,
        input  logic                                  pcIn,
        input  logic                                  irIn,
        input  logic                                  marIn,
        input  logic                                  mdrIn,
        input  logic                                  yIn,
        input  logic                                  zIn,
        input  logic                                  inPortIn,
        input  logic                                  read,
        input  logic                                  hiOut,
        input  logic                                  loOut,
        input  logic                                  zHighOut,
        input  logic                                  zLowOut,
        input  logic                                  pcOut,
        input  logic                                  mdrOut,
        input  logic                                  inPortOut,
        input  datapathPkg::aluOp                     operation,
        input  logic [datapathPkg::wordWidth-1:0]     memDataIn,
        input  logic [datapathPkg::wordWidth-1:0]     inPortData,
        output logic [datapathPkg::wordWidth-1:0]     busData,
        output logic [datapathPkg::wordWidth-1:0]     marAddress,
        output logic [datapathPkg::wordWidth-1:0]     irValue
);

        logic [datapathPkg::wordWidth-1:0]   regSources [datapathPkg::registerCount];
        logic [datapathPkg::wordWidth-1:0]   pc;
        logic [datapathPkg::wordWidth-1:0]   y;
        logic [datapathPkg::wordWidth-1:0]   hi;
        logic [datapathPkg::wordWidth-1:0]   lo;
        logic [datapathPkg::wordWidth-1:0]   inPort;
        logic [datapathPkg::wordWidth-1:0]   mdr;
        logic [2*datapathPkg::wordWidth-1:0] z;
        logic [2*datapathPkg::wordWidth-1:0] aluResult;

        // special registers, each with its own load strobe.
        always_ff @(posedge Clock) begin
                if (reset) begin
                        pc         <= '0;
                        irValue    <= '0;
                        marAddress <= '0;
                        y          <= '0;
                        hi         <= '0;
                        lo         <= '0;
                        inPort     <= '0;
                        z          <= '0;
                end else begin
                        if (pcIn) pc <= busData; // new pc comes back via ZLow.
                        if (irIn) irValue <= busData;
                        if (marIn) marAddress <= busData;
                        if (yIn) y <= busData;
                        if (hiIn) hi <= busData;
                        if (loIn) lo <= busData;
                        if (inPortIn) inPort <= inPortData;
                        if (zIn) z <= aluResult;
                end
        end

        registerFile registerFile_i (
                .Clock      (Clock),
                .reset      (reset),
                .regIn      (regIn),
                .busData    (busData),
                .regSources (regSources)
        );

        memoryDataRegister memoryDataRegister_i (
                .Clock     (Clock),
                .reset     (reset),
                .mdrIn     (mdrIn),
                .read      (read),
                .memDataIn (memDataIn),
                .busData   (busData),
                .mdr       (mdr)
        );

        // Y is operand A, the bus is operand B.
        arithmeticLogicUnit arithmeticLogicUnit_i (
                .operandA  (y),
                .operandB  (busData),
                .operation (operation),
                .result    (aluResult)
        );

        busEncoder busEncoder_i (
                .regSources (regSources),
                .regOut     (regOut),
                .hiOut      (hiOut),
                .loOut      (loOut),
                .zHighOut   (zHighOut),
                .zLowOut    (zLowOut),
                .pcOut      (pcOut),
                .mdrOut     (mdrOut),
                .inPortOut  (inPortOut),
                .hi         (hi),
                .lo         (lo),
                .zHigh      (z[2*datapathPkg::wordWidth-1:datapathPkg::wordWidth]),
                .zLow       (z[datapathPkg::wordWidth-1:0]),
                .pc         (pc),
                .mdr        (mdr),
                .inPort     (inPort),
                .busData    (busData)
        );

endmodule

// File: test/datapathMonitor.sv
module datapathMonitor (
        input  logic                              Clock,
        input  logic [datapathPkg::wordWidth-1:0] busData,
        input  logic [datapathPkg::wordWidth-1:0] marAddress,
        input  logic [datapathPkg::wordWidth-1:0] irValue,
        input  logic [2:0]                        checkMask,
        input  logic [datapathPkg::wordWidth-1:0] expectedValue,
        output int                                errorCount
);

        int busErrors = 0;
        int marErrors = 0;
        int irErrors = 0;

        assign errorCount = busErrors + marErrors + irErrors;

        // mask bits are bus, mar and ir from the low end.
        always @(posedge Clock) begin
                if (checkMask[0] && busData !== expectedValue) begin
                        $display("Fail busData expected %h got %h", expectedValue, busData);
                        busErrors++;
                end
                if (checkMask[1] && marAddress !== expectedValue) begin
                        $display("Fail marAddress expected %h got %h", expectedValue, marAddress);
                        marErrors++;
                end
                if (checkMask[2] && irValue !== expectedValue) begin
                        $display("Fail irValue expected %h got %h", expectedValue, irValue);
                        irErrors++;
                end
        end

        task automatic printCounts(input int assertionFailures);
                $display("errors: busData %0d, marAddress %0d, irValue %0d, assertions %0d",
                        busErrors, marErrors, irErrors, assertionFailures);
        endtask

endmodule

// File: test/datapath_checker.sv
module datapath_checker (
        input logic                                  Clock,
        input logic                                  reset,
        input logic [datapathPkg::registerCount-1:0] regOut,
        input logic                                  hiOut,
        input logic                                  loOut,
        input logic                                  zHighOut,
        input logic                                  zLowOut,
        input logic                                  pcOut,
        input logic                                  mdrOut,
        input logic                                  inPortOut,
        input logic                                  marIn,
        input logic                                  irIn,
        input logic                                  zIn,
        input logic [datapathPkg::wordWidth-1:0]     busData,
        input logic [datapathPkg::wordWidth-1:0]     marAddress,
        input logic [datapathPkg::wordWidth-1:0]     irValue,
        input logic [2*datapathPkg::wordWidth-1:0]   z
);

        int assertionFailures = 0;
        logic anyDrive;

        assign anyDrive = (|regOut) | hiOut | loOut | zHighOut | zLowOut | pcOut | mdrOut
                | inPortOut;

        busIdle: assert property (@(posedge Clock) disable iff (reset) !anyDrive |-> busData == '0)
                else begin
                        assertionFailures++;
                        $error("bus is not zero with no driver active");
                end

        marHold: assert property (@(posedge Clock) disable iff (reset)
                !marIn |=> $stable(marAddress))
                else begin
                        assertionFailures++;
                        $error("marAddress changed without marIn");
                end

        irHold: assert property (@(posedge Clock) disable iff (reset)
                !irIn |=> $stable(irValue))
                else begin
                        assertionFailures++;
                        $error("irValue changed without irIn");
                end

        zHold: assert property (@(posedge Clock) disable iff (reset) !zIn |=> $stable(z))
                else begin
                        assertionFailures++;
                        $error("Z changed without zIn");
                end

endmodule

bind datapath datapath_checker checker_i (
        .Clock      (Clock),
        .reset      (reset),
        .regOut     (regOut),
        .hiOut      (hiOut),
        .loOut      (loOut),
        .zHighOut   (zHighOut),
        .zLowOut    (zLowOut),
        .pcOut      (pcOut),
        .mdrOut     (mdrOut),
        .inPortOut  (inPortOut),
        .marIn      (marIn),
        .irIn       (irIn),
        .zIn        (zIn),
        .busData    (busData),
        .marAddress (marAddress),
        .irValue    (irValue),
        .z          (z)
);

// File: test/datapathTb.sv
module datapathTb;

        // load vector positions above the sixteen general registers.
        typedef enum int {
                ldHi = 16,
                ldLo,
                ldPc,
                ldIr,
                ldMar,
                ldMdr,
                ldY,
                ldZ,
                ldInPort
        } loadTarget;

        typedef struct packed {
                datapathPkg::busSource             drive;
                datapathPkg::busSource             extraDrive;
                logic [24:0]                       loads;
                logic                              read;
                datapathPkg::aluOp                 operation;
                logic [datapathPkg::wordWidth-1:0] memData;
                logic [2:0]                        check; // ir, mar, bus.
                logic [datapathPkg::wordWidth-1:0] expected;
        } stepRow;

        logic                                  Clock;
        logic                                  reset;
        logic [datapathPkg::registerCount-1:0] regIn;
        logic [datapathPkg::registerCount-1:0] regOut;
        logic                                  hiIn;
        logic                                  loIn;
        logic                                  pcIn;
        logic                                  irIn;
        logic                                  marIn;
        logic                                  mdrIn;
        logic                                  yIn;
        logic                                  zIn;
        logic                                  inPortIn;
        logic                                  read;
        logic                                  hiOut;
        logic                                  loOut;
        logic                                  zHighOut;
        logic                                  zLowOut;
        logic                                  pcOut;
        logic                                  mdrOut;
        logic                                  inPortOut;
        datapathPkg::aluOp                     operation;
        logic [datapathPkg::wordWidth-1:0]     memDataIn;
        logic [datapathPkg::wordWidth-1:0]     inPortData;
        logic [datapathPkg::wordWidth-1:0]     busData;
        logic [datapathPkg::wordWidth-1:0]     marAddress;
        logic [datapathPkg::wordWidth-1:0]     irValue;

        logic [24:0]                       loadMask;
        logic [22:0]                       driveMask; // bit index is the busSource value.
        logic [2:0]                        checkMask;
        logic [datapathPkg::wordWidth-1:0] expectedValue;
        logic [31:0]                       rngState;
        stepRow                            steps [$];
        int                                monitorErrors;
        int                                failures;
        int                                cycleCount;
        int                                cycleLimit;

        assign {inPortIn, zIn, yIn, mdrIn, marIn, irIn, pcIn, loIn, hiIn, regIn} = loadMask;
        assign {inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut, regOut} = driveMask;

        datapath dut_i (.*);

        datapathMonitor monitor_i (
                .Clock         (Clock),
                .busData       (busData),
                .marAddress    (marAddress),
                .irValue       (irValue),
                .checkMask     (checkMask),
                .expectedValue (expectedValue),
                .errorCount    (monitorErrors)
        );

        always #2 Clock = ~Clock;

        function automatic logic [31:0] nextRandom();
                rngState ^= rngState << 13;
                rngState ^= rngState >> 17;
                rngState ^= rngState << 5;
                return rngState;
        endfunction

        function automatic logic [24:0] loadOf(input int target);
                logic [24:0] mask;
                mask = '0;
                mask[target] = 1'b1;
                return mask;
        endfunction

        // expected Z for one ALU step.
        function automatic logic [63:0] modelAlu(input datapathPkg::aluOp op, input logic [31:0] a,
                        input logic [31:0] b);
                logic [4:0]  amount;
                logic [63:0] wideA;
                logic [63:0] wideB;
                amount = b[4:0];
                wideA = {{32{a[31]}}, a};
                wideB = {{32{b[31]}}, b};
                case (op)
                        datapathPkg::opAnd: return {32'h0, a & b};
                        datapathPkg::opOr:  return {32'h0, a | b};
                        datapathPkg::opAdd: return {32'h0, a + b};
                        datapathPkg::opSub: return {32'h0, a - b};
                        datapathPkg::opMul: return wideA * wideB; // signed product.
                        datapathPkg::opShr: return {32'h0, a >> amount};
                        datapathPkg::opShl: return {32'h0, a << amount};
                        datapathPkg::opRor: return {32'h0, (a >> amount) | (a << (6'd32 - amount))};
                        datapathPkg::opRol: return {32'h0, (a << amount) | (a >> (6'd32 - amount))};
                        datapathPkg::opNeg: return {32'h0, ~b + 32'd1};
                        datapathPkg::opNot: return {32'h0, ~b};
                        datapathPkg::opInc: return {32'h0, b + 32'd1};
                        default: return 64'h0;
                endcase
        endfunction

        task automatic addStep(input datapathPkg::busSource drive,
                        input datapathPkg::busSource extraDrive, input logic [24:0] loads,
                        input logic readMem, input datapathPkg::aluOp op, input logic [31:0] memData,
                        input logic [2:0] check, input logic [31:0] expected);
                stepRow row;
                row.drive = drive;
                row.extraDrive = extraDrive;
                row.loads = loads;
                row.read = readMem;
                row.operation = op;
                row.memData = memData;
                row.check = check;
                row.expected = expected;
                steps.push_back(row);
        endtask

        task automatic memoryRead(input logic [31:0] word, input logic [2:0] check,
                        input logic [31:0] expected);
                addStep(datapathPkg::srcNone, datapathPkg::srcNone, loadOf(ldMdr), 1'b1,
                        datapathPkg::opAnd, word, check, expected);
        endtask

        task automatic transfer(input datapathPkg::busSource source, input logic [24:0] loads,
                        input datapathPkg::aluOp op);
                addStep(source, datapathPkg::srcNone, loads, 1'b0, op, '0, 3'b000, '0);
        endtask

        task automatic checkBus(input datapathPkg::busSource source, input logic [31:0] expected);
                addStep(source, datapathPkg::srcNone, '0, 1'b0, datapathPkg::opAnd, '0, 3'b001,
                        expected);
        endtask

        // A through Y, then B on the bus into Z.
        task automatic aluStep(input datapathPkg::aluOp op, input logic [31:0] a,
                        input logic [31:0] b);
                memoryRead(a, 3'b000, '0);
                transfer(datapathPkg::srcMdr, loadOf(ldY), datapathPkg::opAnd);
                memoryRead(b, 3'b000, '0);
                transfer(datapathPkg::srcMdr, loadOf(ldZ), op);
        endtask

        task automatic buildTable();
                logic [31:0]       word;
                logic [31:0]       a;
                logic [31:0]       b;
                logic [31:0]       pcValue;
                logic [31:0]       instruction;
                logic [63:0]       zValue;
                logic [31:0]       regModel [16];
                datapathPkg::aluOp op;
                addStep(datapathPkg::srcPc, datapathPkg::srcNone, '0, 1'b0, datapathPkg::opAnd,
                        '0, 3'b111, '0); // all zero after reset.
                for (int i = 0; i < 16; i++) begin
                        word = nextRandom();
                        regModel[i] = word;
                        memoryRead(word, 3'b000, '0);
                        addStep(datapathPkg::srcMdr, datapathPkg::srcNone, loadOf(i), 1'b0,
                                datapathPkg::opAnd, '0, 3'b001, word);
                        checkBus(datapathPkg::busSource'(i), word);
                end
                addStep(datapathPkg::srcR3, datapathPkg::srcR9, '0, 1'b0, datapathPkg::opAnd, '0,
                        3'b001, regModel[3]);
                addStep(datapathPkg::srcHi, datapathPkg::srcR15, '0, 1'b0, datapathPkg::opAnd, '0,
                        3'b001, regModel[15]);
                addStep(datapathPkg::srcInPort, datapathPkg::srcMdr, '0, 1'b0, datapathPkg::opAnd,
                        '0, 3'b001, regModel[15]); // MDR still holds the last word.
                checkBus(datapathPkg::srcNone, '0);
                // MDR also loads from the bus while read is low.
                transfer(datapathPkg::srcR5, loadOf(ldMdr), datapathPkg::opAnd);
                checkBus(datapathPkg::srcMdr, regModel[5]);
                op = datapathPkg::opAnd;
                for (int k = 0; k < op.num(); k++) begin
                        a = nextRandom();
                        b = nextRandom();
                        zValue = modelAlu(op, a, b);
                        aluStep(op, a, b);
                        checkBus(datapathPkg::srcZLow, zValue[31:0]);
                        if (op == datapathPkg::opMul) begin
                                checkBus(datapathPkg::srcZHigh, zValue[63:32]);
                        end
                        op = op.next();
                end
                a = nextRandom();
                b = nextRandom();
                zValue = modelAlu(datapathPkg::opMul, a, b);
                aluStep(datapathPkg::opMul, a, b);
                transfer(datapathPkg::srcZHigh, loadOf(ldHi), datapathPkg::opAnd);
                transfer(datapathPkg::srcZLow, loadOf(ldLo), datapathPkg::opAnd);
                checkBus(datapathPkg::srcHi, zValue[63:32]);
                checkBus(datapathPkg::srcLo, zValue[31:0]);
                // fetch: PC to MAR, word to IR, PC advanced through the ALU.
                pcValue = nextRandom();
                instruction = nextRandom();
                memoryRead(pcValue, 3'b000, '0);
                transfer(datapathPkg::srcMdr, loadOf(ldPc), datapathPkg::opAnd);
                transfer(datapathPkg::srcPc, loadOf(ldMar) | loadOf(ldZ), datapathPkg::opInc);
                memoryRead(instruction, 3'b010, pcValue);
                transfer(datapathPkg::srcMdr, loadOf(ldIr), datapathPkg::opAnd);
                addStep(datapathPkg::srcZLow, datapathPkg::srcNone, loadOf(ldPc), 1'b0,
                        datapathPkg::opAnd, '0, 3'b001, pcValue + 32'd1);
                addStep(datapathPkg::srcNone, datapathPkg::srcNone, '0, 1'b0, datapathPkg::opAnd,
                        '0, 3'b100, instruction);
                checkBus(datapathPkg::srcPc, pcValue + 32'd1);
                transfer(datapathPkg::srcNone, loadOf(ldInPort), datapathPkg::opAnd);
                checkBus(datapathPkg::srcInPort, inPortData);
                checkBus(datapathPkg::srcNone, '0);
        endtask

        task automatic applyStep(input stepRow row);
                driveMask = '0;
                if (row.drive != datapathPkg::srcNone) driveMask[row.drive] = 1'b1;
                if (row.extraDrive != datapathPkg::srcNone) driveMask[row.extraDrive] = 1'b1;
                loadMask = row.loads;
                read = row.read;
                operation = row.operation;
                memDataIn = row.memData;
                checkMask = row.check;
                expectedValue = row.expected;
        endtask

        task automatic clearInputs();
                loadMask = '0;
                driveMask = '0;
                read = 1'b0;
                operation = datapathPkg::opAnd;
                memDataIn = '0;
                checkMask = '0;
                expectedValue = '0;
        endtask

        always @(posedge Clock) begin
                cycleCount++;
                if (cycleCount >= cycleLimit) begin
                        $display("Run timed out after %0d cycles", cycleCount);
                        $display("Some tests failed");
                        $finish;
                end
        end

        initial begin
                Clock = 1'b0;
                reset = 1'b1;
                cycleCount = 0;
                rngState = 32'he85a7749;
                clearInputs();
                inPortData = nextRandom();
                buildTable();
                cycleLimit = steps.size() * 2 + 20;
                repeat (5) @(posedge Clock);
                @(negedge Clock);
                reset = 1'b0;
                foreach (steps[i]) begin
                        applyStep(steps[i]);
                        @(negedge Clock);
                end
                clearInputs();
                failures = monitorErrors + dut_i.checker_i.assertionFailures;
                monitor_i.printCounts(dut_i.checker_i.assertionFailures);
                if (failures == 0) begin
                        $display("All tests passed");
                end else begin
                        $display("Some tests failed");
                end
                $finish;
        end

endmodule

// File: compile.f
common/datapathPkg.sv
logic/busEncoder.sv
logic/registerFile.sv
logic/memoryDataRegister.sv
alu/arithmeticLogicUnit.sv
logic/datapath.sv
test/datapathMonitor.sv
test/datapath_checker.sv
test/datapathTb.sv

// File: Bender.yml
package:
  name: datapath

sources:
  - common/datapathPkg.sv
  - logic/busEncoder.sv
  - logic/registerFile.sv
  - logic/memoryDataRegister.sv
  - alu/arithmeticLogicUnit.sv
  - logic/datapath.sv
  - target: test
    files:
      - test/datapathMonitor.sv
      - test/datapath_checker.sv
      - test/datapathTb.sv
